//--- Bender.yml
package:
  name: epd_ctrl

sources:
  - logic/epd_cmd_pkg.sv
  - logic/epd_timing_pkg.sv
  - logic/spi_byte_if.sv
  - logic/spi_byte_tx.sv
  - logic/busy_monitor.sv
  - logic/init_cmd_rom.sv
  - logic/epd_sequencer.sv
  - logic/epd_ctrl_top.sv
  - target: test
    files:
      - verification/epd_panel_model.sv
      - verification/epd_ctrl_tb.sv

//--- logic/busy_monitor.sv
module busy_monitor (
    input  logic clk,
    input  logic reset_n,
    input  logic wait_start,
    input  logic epd_busy,
    output logic wait_end
);
    import epd_timing_pkg::*;

    typedef enum logic [1:0] {MON_IDLE, MON_ARMING, MON_WAITING} mon_state_t;

    mon_state_t  state;
    wait_count_t timer;
    logic        finish;

    // Timer holds the cycles elapsed since the start pulse
    assign finish = !epd_busy || timer == wait_count_t'(BUSY_TIMEOUT - 1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= MON_IDLE;
            timer    <= '0;
            wait_end <= 1'b0;
        end else begin
            wait_end <= 1'b0;
            case (state)
                MON_IDLE: begin
                    // Busy is not sampled in the start cycle itself
                    if (wait_start) begin
                        state <= MON_ARMING;
                        timer <= wait_count_t'(1);
                    end
                end
                MON_ARMING: begin
                    // First look at the panel, busy may already be up
                    timer <= timer + 1'b1;
                    if (finish) begin
                        wait_end <= 1'b1;
                        state    <= MON_IDLE;
                    end else begin
                        state <= MON_WAITING;
                    end
                end
                default: begin
                    timer <= timer + 1'b1;
                    if (finish) begin
                        wait_end <= 1'b1;
                        state    <= MON_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- logic/epd_cmd_pkg.sv
package epd_cmd_pkg;

    typedef logic [7:0] epd_byte_t;

    // Bit 8 set marks a data byte, clear marks a command
    typedef logic [8:0] init_entry_t;

    localparam epd_byte_t CMD_WRITE_BW    = 8'h24;
    localparam epd_byte_t CMD_WRITE_RED   = 8'h26;
    localparam epd_byte_t CMD_UPDATE_CTRL = 8'h22;
    localparam epd_byte_t UPDATE_MODE     = 8'hF7;
    localparam epd_byte_t CMD_MASTER_ACT  = 8'h20;
    localparam epd_byte_t CMD_DEEP_SLEEP  = 8'h10;
    localparam epd_byte_t SLEEP_MODE      = 8'h01;
    localparam epd_byte_t FILL_WHITE      = 8'hFF;

    localparam int INIT_LEN = 12;

    localparam init_entry_t INIT_TABLE [INIT_LEN] = '{
        {1'b0, 8'h12},                               // Soft reset
        {1'b0, 8'h01}, {1'b1, 8'h03}, {1'b1, 8'h00}, {1'b1, 8'h00},
        {1'b0, 8'h11}, {1'b1, 8'h03},                // X and Y increment
        {1'b0, 8'h44}, {1'b1, 8'h00}, {1'b1, 8'h01}, // RAM X window
        {1'b0, 8'h3C}, {1'b1, 8'h05}                 // Border waveform
    };

endpackage

//--- logic/epd_ctrl_top.sv
module epd_ctrl_top (
    input  logic clk,
    input  logic reset_n,
    input  logic epd_busy,
    output logic epd_sclk,
    output logic epd_sdin,
    output logic epd_cs,
    output logic epd_dc,
    output logic epd_res,
    output logic sequence_done
);
    import epd_cmd_pkg::*;
    import epd_timing_pkg::*;

    init_addr_t init_addr;
    epd_byte_t  init_byte;
    logic       init_is_data;
    logic       wait_start;
    logic       wait_end;

    spi_byte_if byte_link ();

    spi_byte_tx u_spi_byte_tx (
        .clk     (clk),
        .reset_n (reset_n),
        .link    (byte_link.serializer),
        .sclk    (epd_sclk),
        .sdin    (epd_sdin)
    );

    busy_monitor u_busy_monitor (
        .clk        (clk),
        .reset_n    (reset_n),
        .wait_start (wait_start),
        .epd_busy   (epd_busy),
        .wait_end   (wait_end)
    );

    init_cmd_rom u_init_cmd_rom (
        .init_addr    (init_addr),
        .init_byte    (init_byte),
        .init_is_data (init_is_data)
    );

    epd_sequencer u_epd_sequencer (
        .clk           (clk),
        .reset_n       (reset_n),
        .link          (byte_link.sequencer),
        .init_addr     (init_addr),
        .init_byte     (init_byte),
        .init_is_data  (init_is_data),
        .wait_start    (wait_start),
        .wait_end      (wait_end),
        .epd_cs        (epd_cs),
        .epd_dc        (epd_dc),
        .epd_res       (epd_res),
        .sequence_done (sequence_done)
    );

endmodule

//--- logic/epd_sequencer.sv
module epd_sequencer (
    input  logic                       clk,
    input  logic                       reset_n,
    spi_byte_if.sequencer              link,
    output epd_timing_pkg::init_addr_t init_addr,
    input  epd_cmd_pkg::epd_byte_t     init_byte,
    input  logic                       init_is_data,
    output logic                       wait_start,
    input  logic                       wait_end,
    output logic                       epd_cs,
    output logic                       epd_dc,
    output logic                       epd_res,
    output logic                       sequence_done
);
    import epd_cmd_pkg::*;
    import epd_timing_pkg::*;

    typedef enum logic [2:0] {
        ST_RESET, ST_INIT, ST_INIT_WAIT, ST_CLEAR, ST_UPDATE, ST_SLEEP, ST_DONE
    } state_t;

    typedef enum logic [1:0] {STEP_ISSUE, STEP_XFER, STEP_BUSY} step_t;

    state_t      state;
    step_t       step;
    wait_count_t count;
    buf_count_t  byte_cnt;
    logic        second_buf;
    epd_byte_t   next_byte;
    logic        next_is_data;
    logic        issue;

    // Byte to send next in the current stage
    always_comb begin
        next_byte    = init_byte;
        next_is_data = init_is_data;
        case (state)
            ST_CLEAR: begin
                if (byte_cnt == '0) begin
                    next_byte    = second_buf ? CMD_WRITE_RED : CMD_WRITE_BW;
                    next_is_data = 1'b0;
                end else begin
                    next_byte    = FILL_WHITE;
                    next_is_data = 1'b1;
                end
            end
            ST_UPDATE: begin
                case (byte_cnt)
                    buf_count_t'(0): next_byte = CMD_UPDATE_CTRL;
                    buf_count_t'(1): next_byte = UPDATE_MODE;
                    default:         next_byte = CMD_MASTER_ACT;
                endcase
                next_is_data = byte_cnt == buf_count_t'(1);
            end
            ST_SLEEP: begin
                next_byte    = (byte_cnt == '0) ? CMD_DEEP_SLEEP : SLEEP_MODE;
                next_is_data = byte_cnt != '0;
            end
            default: ;
        endcase
    end

    assign issue = state inside {ST_INIT, ST_CLEAR, ST_UPDATE, ST_SLEEP}
                   && step == STEP_ISSUE && !link.tx_busy;

    assign sequence_done = state == ST_DONE;

    always_ff @(posedge clk) begin
        if (issue) begin
            link.tx_byte <= next_byte;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state         <= ST_RESET;
            step          <= STEP_ISSUE;
            count         <= '0;
            byte_cnt      <= '0;
            second_buf    <= 1'b0;
            init_addr     <= '0;
            link.tx_start <= 1'b0;
            wait_start    <= 1'b0;
            epd_cs        <= 1'b1;
            epd_dc        <= 1'b0;
            epd_res       <= 1'b1;
        end else begin
            link.tx_start <= 1'b0;
            wait_start    <= 1'b0;

            if (issue) begin
                epd_cs        <= 1'b0;
                epd_dc        <= next_is_data;
                link.tx_start <= 1'b1;
                step          <= STEP_XFER;
            end

            if (state == ST_RESET) begin
                // Panel reset line goes high, low, high
                count <= count + 1'b1;
                if (count == wait_count_t'(STARTUP_WAIT - 1)) begin
                    epd_res <= 1'b0;
                end
                if (count == wait_count_t'(2 * STARTUP_WAIT - 1)) begin
                    epd_res <= 1'b1;
                end
                if (count == wait_count_t'(3 * STARTUP_WAIT - 1)) begin
                    state <= ST_INIT;
                end
            end else if (step == STEP_XFER && link.tx_done) begin
                case (state)
                    ST_INIT: begin
                        epd_cs <= 1'b1;
                        // Busy wait after soft reset and after the last entry
                        if (init_addr == '0 || init_addr == init_addr_t'(INIT_LEN - 1)) begin
                            wait_start <= 1'b1;
                            step       <= STEP_BUSY;
                        end else begin
                            init_addr <= init_addr + 1'b1;
                            step      <= STEP_ISSUE;
                        end
                        if (init_addr == init_addr_t'(INIT_LEN - 1)) begin
                            state <= ST_INIT_WAIT;
                        end
                    end
                    ST_CLEAR: begin
                        step <= STEP_ISSUE;
                        if (byte_cnt == buf_count_t'(BUFFER_BYTES)) begin
                            epd_cs     <= 1'b1;
                            byte_cnt   <= '0;
                            second_buf <= 1'b1;
                            if (second_buf) begin
                                state <= ST_UPDATE;
                            end
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                    ST_UPDATE: begin
                        if (byte_cnt == buf_count_t'(2)) begin
                            epd_cs     <= 1'b1;
                            wait_start <= 1'b1;
                            step       <= STEP_BUSY;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            step     <= STEP_ISSUE;
                        end
                    end
                    default: begin
                        // Sleep command then its mode byte
                        step <= STEP_ISSUE;
                        if (byte_cnt == buf_count_t'(1)) begin
                            epd_cs <= 1'b1;
                            state  <= ST_DONE;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                endcase
            end else if (step == STEP_BUSY && wait_end) begin
                step <= STEP_ISSUE;
                case (state)
                    ST_INIT:      init_addr <= init_addr + 1'b1;
                    ST_INIT_WAIT: state <= ST_CLEAR;
                    default: begin
                        byte_cnt <= '0;
                        state    <= ST_SLEEP;
                    end
                endcase
            end
        end
    end

endmodule

//--- logic/epd_timing_pkg.sv
package epd_timing_pkg;

    // Small test geometry
    localparam int EPD_WIDTH  = 16;
    localparam int EPD_HEIGHT = 4;

    // One bit per pixel, so eight pixels per byte
    localparam int BUFFER_BYTES = (EPD_WIDTH / 8) * EPD_HEIGHT;

    typedef logic [$clog2(BUFFER_BYTES + 1)-1:0] buf_count_t;

    // Length of each panel reset phase
    localparam int STARTUP_WAIT = 8;

    // Upper bound on any wait for the busy line
    localparam int BUSY_TIMEOUT = 200;

    typedef logic [15:0] wait_count_t;

    typedef logic [3:0] init_addr_t;

endpackage

//--- logic/init_cmd_rom.sv
module init_cmd_rom (
    input  epd_timing_pkg::init_addr_t init_addr,
    output epd_cmd_pkg::epd_byte_t     init_byte,
    output logic                       init_is_data
);
    import epd_cmd_pkg::*;

    init_entry_t entry;

    // Out-of-range addresses give a zero command
    always_comb begin
        case (init_addr) inside
            [0:INIT_LEN-1]: entry = INIT_TABLE[init_addr];
            default:        entry = '0;
        endcase
    end

    assign init_byte    = entry[7:0];
    assign init_is_data = entry[8];

endmodule

//--- logic/spi_byte_if.sv
interface spi_byte_if;
    import epd_cmd_pkg::*;

    epd_byte_t tx_byte;
    logic      tx_start;
    logic      tx_busy;
    logic      tx_done;

    // Start is a single-cycle pulse, only while busy is low
    modport sequencer (
        output tx_byte, tx_start,
        input  tx_busy, tx_done
    );

    modport serializer (
        input  tx_byte, tx_start,
        output tx_busy, tx_done
    );

endinterface

//--- logic/spi_byte_tx.sv
module spi_byte_tx (
    input  logic              clk,
    input  logic              reset_n,
    spi_byte_if.serializer    link,
    output logic              sclk,
    output logic              sdin
);
    import epd_cmd_pkg::*;

    epd_byte_t  shift_q;
    logic [2:0] bit_idx;
    logic       busy_q;
    logic       done_q;

    assign link.tx_busy = busy_q;
    assign link.tx_done = done_q;

    // Byte held for the whole transfer
    always_ff @(posedge clk) begin
        if (link.tx_start && !busy_q) begin
            shift_q <= link.tx_byte;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sclk    <= 1'b0;
            sdin    <= 1'b0;
            bit_idx <= 3'd0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!busy_q) begin
                sclk <= 1'b0;
                if (link.tx_start) begin
                    busy_q  <= 1'b1;
                    bit_idx <= 3'd7;
                    sdin    <= link.tx_byte[7];
                end
            end else if (sclk) begin
                // Falling edge, next bit goes out while clock is low
                sclk    <= 1'b0;
                bit_idx <= bit_idx - 3'd1;
                sdin    <= shift_q[bit_idx - 3'd1];
            end else begin
                sclk <= 1'b1;
                // Eighth high phase overlaps the done cycle
                if (bit_idx == 3'd0) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

endmodule

//--- tb.f
logic/epd_cmd_pkg.sv
logic/epd_timing_pkg.sv
logic/spi_byte_if.sv
logic/spi_byte_tx.sv
logic/busy_monitor.sv
logic/init_cmd_rom.sv
logic/epd_sequencer.sv
logic/epd_ctrl_top.sv
verification/epd_panel_model.sv
verification/epd_ctrl_tb.sv

//--- verification/epd_ctrl_tb.sv
module epd_ctrl_tb;
    import epd_cmd_pkg::*;
    import epd_timing_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 3;
    localparam int NUM_ROWS        = 3;
    localparam int EXP_LEN         = INIT_LEN + 2 * (BUFFER_BYTES + 1) + 5;
    localparam int ROW_CYCLES      = EXP_LEN * 18 + 3 * STARTUP_WAIT + RESET_CYCLES
                                     + 4 * BUSY_TIMEOUT;
    localparam int WATCHDOG_CYCLES = 3 * NUM_ROWS * ROW_CYCLES;
    // One byte slot for the serial clock to restart once busy falls
    localparam int RESUME_CYCLES   = 18;

    typedef struct packed {
        logic [15:0] hold;
        logic        stuck;
        logic        overlap;
    } scenario_t;

    // Busy hold base, stuck flag and whether sclk edges are expected under busy
    localparam scenario_t SCENARIOS [NUM_ROWS] = '{
        '{16'd5,  1'b0, 1'b0},
        '{16'd40, 1'b0, 1'b0},
        '{16'd0,  1'b1, 1'b1}
    };

    logic      clk;
    logic      reset_n;
    logic      epd_busy;
    logic      epd_sclk;
    logic      epd_sdin;
    logic      epd_cs;
    logic      epd_dc;
    logic      epd_res;
    logic      sequence_done;
    int        hold_len;
    logic      stuck;
    logic      rx_valid;
    epd_byte_t rx_byte;
    logic      rx_is_data;

    epd_byte_t exp_byte [EXP_LEN];
    logic      exp_dc [EXP_LEN];
    int        exp_frame [EXP_LEN];
    int        exp_count;
    int        rx_count;
    int        frame_count;
    int        overlap_edges;
    logic      cs_q;
    logic      sclk_q;
    logic      busy_q;
    logic      resume_pending;
    int        resume_gap;
    int        errors;
    int        seed;

    epd_ctrl_top DUT (
        .clk           (clk),
        .reset_n       (reset_n),
        .epd_busy      (epd_busy),
        .epd_sclk      (epd_sclk),
        .epd_sdin      (epd_sdin),
        .epd_cs        (epd_cs),
        .epd_dc        (epd_dc),
        .epd_res       (epd_res),
        .sequence_done (sequence_done)
    );

    epd_panel_model panel (
        .clk         (clk),
        .reset_n     (reset_n),
        .sclk        (epd_sclk),
        .sdin        (epd_sdin),
        .cs          (epd_cs),
        .dc          (epd_dc),
        .hold_cycles (hold_len),
        .stuck       (stuck),
        .busy        (epd_busy),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte),
        .rx_is_data  (rx_is_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("MISMATCH %s exp %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic push_expected(input epd_byte_t b, input logic is_data, input int frame);
        exp_byte[exp_count]  = b;
        exp_dc[exp_count]    = is_data;
        exp_frame[exp_count] = frame;
        exp_count++;
    endtask

    // Init table, both cleared buffers, then update and sleep
    // Frame index counts chip select low phases
    task automatic build_expected();
        exp_count = 0;
        for (int i = 0; i < INIT_LEN; i++) begin
            push_expected(INIT_TABLE[i][7:0], INIT_TABLE[i][8], i);
        end
        push_expected(CMD_WRITE_BW, 1'b0, INIT_LEN);
        repeat (BUFFER_BYTES) push_expected(FILL_WHITE, 1'b1, INIT_LEN);
        push_expected(CMD_WRITE_RED, 1'b0, INIT_LEN + 1);
        repeat (BUFFER_BYTES) push_expected(FILL_WHITE, 1'b1, INIT_LEN + 1);
        push_expected(CMD_UPDATE_CTRL, 1'b0, INIT_LEN + 2);
        push_expected(UPDATE_MODE, 1'b1, INIT_LEN + 2);
        push_expected(CMD_MASTER_ACT, 1'b0, INIT_LEN + 2);
        push_expected(CMD_DEEP_SLEEP, 1'b0, INIT_LEN + 3);
        push_expected(SLEEP_MODE, 1'b1, INIT_LEN + 3);
    endtask

    // Decoded bytes against the expected list
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_count       <= 0;
            frame_count    <= 0;
            overlap_edges  <= 0;
            cs_q           <= 1'b1;
            sclk_q         <= 1'b0;
            busy_q         <= 1'b0;
            resume_pending <= 1'b0;
            resume_gap     <= 0;
        end else begin
            cs_q   <= epd_cs;
            sclk_q <= epd_sclk;
            busy_q <= epd_busy;
            if (cs_q && !epd_cs) begin
                frame_count <= frame_count + 1;
            end
            if (epd_sclk && !sclk_q && epd_busy) begin
                overlap_edges <= overlap_edges + 1;
            end
            // Serial clock has to come back soon after the panel drops busy
            if (!epd_busy && busy_q) begin
                resume_pending <= 1'b1;
                resume_gap     <= 1;
            end else if (resume_pending) begin
                if (epd_sclk && !sclk_q) begin
                    resume_pending <= 1'b0;
                    assert (resume_gap <= RESUME_CYCLES) else begin
                        $display("Transfers resumed %0d cycles after busy fell", resume_gap);
                        errors++;
                    end
                end else begin
                    resume_gap <= resume_gap + 1;
                end
            end
            if (rx_valid) begin
                rx_count <= rx_count + 1;
                assert (rx_count < EXP_LEN) else begin
                    $display("Panel received more bytes than the sequence holds");
                    errors++;
                end
                if (rx_count < EXP_LEN) begin
                    check_value($sformatf("rx_byte[%0d]", rx_count), rx_byte,
                                exp_byte[rx_count]);
                    check_value($sformatf("epd_dc[%0d]", rx_count), rx_is_data,
                                exp_dc[rx_count]);
                    check_value($sformatf("cs_frame[%0d]", rx_count), frame_count - 1,
                                exp_frame[rx_count]);
                end
            end
        end
    end

    task automatic run_scenario(input int r);
        int hold;
        hold = SCENARIOS[r].hold + ($unsigned($random(seed)) % 8);
        @(posedge clk);
        reset_n  <= 1'b0;
        hold_len <= hold;
        stuck    <= SCENARIOS[r].stuck;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        // Panel reset pulse high, low, high with the serial clock idle
        for (int j = 1; j <= 3 * STARTUP_WAIT; j++) begin
            @(posedge clk);
            check_value("epd_res", epd_res, j <= STARTUP_WAIT || j > 2 * STARTUP_WAIT);
            check_value("epd_sclk", epd_sclk, 0);
        end
        while (!sequence_done) @(posedge clk);
        repeat (8) begin
            @(posedge clk);
            check_value("sequence_done", sequence_done, 1);
            check_value("epd_cs", epd_cs, 1);
        end
        check_value("byte_count", rx_count, EXP_LEN);
        check_value("busy_overlap", overlap_edges != 0, SCENARIOS[r].overlap);
        $display("Scenario %0d with busy hold %0d and stuck %0d finished", r, hold,
                 SCENARIOS[r].stuck);
    endtask

    initial begin
        seed     = 63552;
        errors   = 0;
        reset_n  = 1'b0;
        hold_len = 0;
        stuck    = 1'b0;
        build_expected();
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_scenario(r);
        end
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, power-up sequence did not finish",
                 WATCHDOG_CYCLES);
        $display("Checks done with %0d errors", errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- verification/epd_panel_model.sv
module epd_panel_model (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   sclk,
    input  logic                   sdin,
    input  logic                   cs,
    input  logic                   dc,
    input  int                     hold_cycles,
    input  logic                   stuck,
    output logic                   busy,
    output logic                   rx_valid,
    output epd_cmd_pkg::epd_byte_t rx_byte,
    output logic                   rx_is_data
);
    import epd_cmd_pkg::*;

    localparam epd_byte_t SOFT_RESET = 8'h12;

    epd_byte_t  shift;
    epd_byte_t  full_byte;
    logic [2:0] bit_cnt;
    logic       sclk_q;
    logic       cs_q;
    logic       arm;
    int         byte_total;
    int         busy_left;

    assign full_byte = {shift[6:0], sdin};

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            shift      <= '0;
            bit_cnt    <= '0;
            sclk_q     <= 1'b0;
            cs_q       <= 1'b1;
            arm        <= 1'b0;
            byte_total <= 0;
            busy_left  <= 0;
            busy       <= 1'b0;
            rx_valid   <= 1'b0;
            rx_byte    <= '0;
            rx_is_data <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            sclk_q   <= sclk;
            cs_q     <= cs;
            // Panel samples data on the rising serial clock
            if (sclk && !sclk_q && !cs) begin
                shift   <= full_byte;
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    rx_byte    <= full_byte;
                    rx_is_data <= dc;
                    rx_valid   <= 1'b1;
                    byte_total <= byte_total + 1;
                    arm <= (!dc && (full_byte == SOFT_RESET || full_byte == CMD_MASTER_ACT))
                           || byte_total + 1 == INIT_LEN;
                end
            end
            // Busy goes up once chip select is released
            if (cs && !cs_q && arm) begin
                arm       <= 1'b0;
                busy      <= 1'b1;
                busy_left <= hold_cycles;
            end else if (busy && !stuck) begin
                if (busy_left <= 1) begin
                    busy <= 1'b0;
                end
                busy_left <= busy_left - 1;
            end
        end
    end

endmodule
